//--- Makefile
# Verilator flow for the instruction front end testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module cpuFrontTb -f project.f

# The run passes only if the pass line appears in the output
sim:
	verilator --binary --timing --assert --top-module cpuFrontTb -f project.f
	./obj_dir/VcpuFrontTb | tee /dev/stderr | grep -x "test passed" > /dev/null

clean:
	rm -rf obj_dir

//--- design/cpuFront.sv
// Top of the instruction front end: sequencer, microprogram, IR and operands
// Decodes the Via strobes into Done, SC, LE_Int and the IR load enable

`timescale 1ns/10ps

module cpuFront
    import cpuFrontPkg::*;
#(
    parameter int          uAddrWidth  = 5,
    parameter logic [15:0] resetVector = 16'hFFFC
)(
    input  logic        Clk,
    input  logic        arstN,
    input  logic        Int,                // Interrupt request
    input  logic        Wait,               // Memory not ready
    input  logic [15:0] Vector,
    input  logic [7:0]  DI,
    output logic        Done,               // Last cycle of the instruction
    output logic        SC,
    output logic        Rdy,
    output logic        LE_Int,
    output logic        VP,
    output ioOpT        IO_Op,
    output logic [7:0]  DO,
    output logic [7:0]  IR,
    output logic [7:0]  OP1,
    output logic [7:0]  OP2,
    output modeT        Mode,
    output logic        RMW,
    output prefixT      prefix
);

    ////////////////////////////////////////////////////////////////////////////
    // Strobe decode

    microWordT             uPL;
    logic [uAddrWidth-1:0] MA;
    logic [uAddrWidth-1:0] dispatchAddr;
    uBaT                   dispatchBa;      // Entry from the classifier
    logic                  brv1, brv2, brv3;
    logic                  irLoad;
    logic                  phw;

    assign Rdy  = ~Wait;                    // No ALU, so only the bus stalls
    assign brv1 = (uPL.via == viaBrv1);
    assign brv2 = (uPL.via == viaBrv2);
    assign brv3 = (uPL.via == viaBrv3);

    assign Done   = (uPL.via != viaNone);
    assign SC     = brv3;
    assign LE_Int = brv2;
    assign IO_Op  = uPL.ioOp;

    // An interrupt taken at fetch leaves IR alone
    assign irLoad       = (brv1 | (brv3 & ~Int)) & Rdy;
    assign dispatchAddr = uAddrWidth'(dispatchBa);

    ////////////////////////////////////////////////////////////////////////////
    // Units

    microSequencer #(.uAddrWidth(uAddrWidth)) uSeq (
        .Clk(Clk), .arstN(arstN), .Rdy(Rdy),
        .uPL(uPL), .Int(Int),
        .dispatchAddr(dispatchAddr),
        .MA(MA)
    );

    microProgramRom #(.uAddrWidth(uAddrWidth)) uRom (
        .Clk(Clk), .arstN(arstN), .Rdy(Rdy),
        .MA(MA),
        .uPL(uPL)                           // Registered microword
    );

    instructionUnit uInst (
        .Clk(Clk), .arstN(arstN),
        .irLoad(irLoad), .DI(DI),
        .dispatchAddr(dispatchBa),
        .IR(IR), .Mode(Mode), .RMW(RMW),
        .phw(phw), .prefix(prefix)
    );

    operandPath #(.resetVector(resetVector)) uOper (
        .Clk(Clk), .arstN(arstN), .Rdy(Rdy),
        .uPL(uPL), .loadVector(brv2), .phw(phw),
        .DI(DI), .Vector(Vector),
        .OP1(OP1), .OP2(OP2), .DO(DO), .VP(VP)
    );

endmodule

//--- design/cpuFrontPkg.sv
// Shared types and constants for the 6502-family instruction front end
// Each design file pulls this in with a wildcard import in its module header

package cpuFrontPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes the front end recognises by value

    localparam logic [7:0] opNop    = 8'hEA;    // Loaded into IR at reset
    localparam logic [7:0] opBrk    = 8'h00;
    localparam logic [7:0] opCop    = 8'h02;
    localparam logic [7:0] opPhw    = 8'hF4;    // Push word {OP2, OP1}
    localparam logic [7:0] opPfxOsy = 8'h8B;
    localparam logic [7:0] opPfxInd = 8'h9B;
    localparam logic [7:0] opPfxSiz = 8'hAB;
    localparam logic [7:0] opPfxIsz = 8'hBB;    // IND and SIZ together
    localparam logic [7:0] opPfxOax = 8'hEB;
    localparam logic [7:0] opPfxOay = 8'hFB;

    ////////////////////////////////////////////////////////////////////////////
    // Microprogram fields

    typedef logic [4:0] uBaT;                   // Branch address field

    // Routine entry points in the microprogram
    localparam uBaT entryReset = 5'd0;
    localparam uBaT entryFetch = 5'd2;
    localparam uBaT entryInt   = 5'd3;          // Interrupt handler
    localparam uBaT entryOne   = 5'd5;          // One operand byte
    localparam uBaT entryTwo   = 5'd7;          // Two operand bytes
    localparam uBaT entryPhw   = 5'd10;         // Two reads, two writes

    typedef enum logic [1:0] {
        viaNone = 2'b00,
        viaBrv1 = 2'b01,                        // Dispatch on DI
        viaBrv2 = 2'b10,                        // Vector load, LE_Int
        viaBrv3 = 2'b11                         // Fetch and dispatch, Int test
    } viaT;

    typedef enum logic [1:0] {
        ioIdle  = 2'b00,
        ioWrite = 2'b01,
        ioRead  = 2'b10,
        ioFetch = 2'b11
    } ioOpT;

    typedef enum logic [2:0] {
        modeValid   = 3'd0,
        modeInvalid = 3'd1,
        modeCop     = 3'd2,
        modeBrk     = 3'd3,
        modeSpecial = 3'd5,                     // PHW
        modePrefix  = 3'd6
    } modeT;

    // Same bit position names the same operand register in both views
    typedef struct packed {
        logic ir;                               // IR destination
        logic op1;
        logic op2;
    } diSelT;

    typedef struct packed {
        logic none;                             // No source, DO stays 0
        logic lo;                               // Low byte, OP1
        logic hi;                               // High byte, OP2
    } doSelT;

    // Read cycles decode the field as a destination, write cycles as a source
    typedef union packed {
        diSelT diSel;
        doSelT doSel;
    } ioSelU;

    typedef struct packed {
        logic  jump;                            // Load MA from ba
        viaT   via;
        uBaT   ba;
        ioOpT  ioOp;
        ioSelU ioSel;
        logic  isr;                             // Strobe, VP takes vp
        logic  vp;
    } microWordT;

    localparam microWordT uIdleWord = '0;       // No Via, no bus cycle

    typedef struct packed {
        logic ind;
        logic siz;
        logic oax;
        logic oay;
        logic osy;
    } prefixT;

    typedef struct packed {
        modeT       mode;
        logic       rmw;
        logic [1:0] opCnt;                      // Operand bytes to read
        prefixT     prefix;                     // Flags this byte sets
        logic       phw;
    } decodeT;

endpackage

//--- design/instructionUnit.sv
// Instruction register, opcode classifier, decode register and prefix flags
// DI is classified as it arrives; the same decode is registered with IR

`timescale 1ns/10ps

module instructionUnit
    import cpuFrontPkg::*;
(
    input  logic       Clk,
    input  logic       arstN,
    input  logic       irLoad,              // Opcode on DI this cycle
    input  logic [7:0] DI,
    output uBaT        dispatchAddr,        // Entry for the byte on DI
    output logic [7:0] IR,
    output modeT       Mode,
    output logic       RMW,
    output logic       phw,
    output prefixT     prefix
);

    ////////////////////////////////////////////////////////////////////////////
    // Opcode classifier

    function automatic decodeT classify(input logic [7:0] op);
        decodeT d;
        d = '0;
        case (op)
            opPfxOsy: begin d.mode = modePrefix; d.prefix.osy = 1'b1; end
            opPfxInd: begin d.mode = modePrefix; d.prefix.ind = 1'b1; end
            opPfxSiz: begin d.mode = modePrefix; d.prefix.siz = 1'b1; end
            opPfxOax: begin d.mode = modePrefix; d.prefix.oax = 1'b1; end
            opPfxOay: begin d.mode = modePrefix; d.prefix.oay = 1'b1; end
            opPfxIsz:
            begin
                d.mode       = modePrefix;
                d.prefix.ind = 1'b1;
                d.prefix.siz = 1'b1;
            end
            opPhw:
            begin
                d.mode = modeSpecial;
                d.phw  = 1'b1;
            end
            opBrk:   d.mode = modeBrk;
            opCop:   d.mode = modeCop;
            default: d.mode = (op[3:0] == 4'hB) ? modeInvalid : modeValid;
        endcase
        // Operand count from the low nibble
        if ((op[3:2] == 2'b11) || d.phw)
            d.opCnt = 2'd2;
        else if (op[0] || (op[3:2] == 2'b01))
            d.opCnt = 2'd1;
        else
            d.opCnt = 2'd0;
        d.rmw = (op[2:1] == 2'b11) && !op[0];
        return d;
    endfunction

    decodeT newDec;                         // Decode of the byte on DI
    decodeT dec;                            // Decode of IR
    prefixT p;                              // Flags set by the incoming byte

    assign newDec = classify(DI);
    assign p      = newDec.prefix;

    // Routine entry, PHW has its own routine
    always_comb
    begin
        if (newDec.phw)
            dispatchAddr = entryPhw;
        else if (newDec.opCnt == 2'd2)
            dispatchAddr = entryTwo;
        else if (newDec.opCnt == 2'd1)
            dispatchAddr = entryOne;
        else
            dispatchAddr = entryFetch;      // No operand, straight back
    end

    ////////////////////////////////////////////////////////////////////////////
    // IR, decode and prefix registers

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            IR     <= opNop;
            dec    <= '0;                   // NOP decode
            prefix <= '0;
        end
        else if (irLoad)
        begin
            IR  <= DI;
            dec <= newDec;
            if (newDec.mode != modePrefix)
            begin
                prefix <= '0;               // Any real opcode ends the chain
            end
            else
            begin
                prefix.ind <= p.ind | prefix.ind;
                prefix.siz <= p.siz | prefix.siz;
                prefix.oax <= p.oax | (prefix.oax & ~p.oay);
                prefix.oay <= p.oay | (prefix.oay & ~p.osy & ~p.oax);
                prefix.osy <= p.osy | (prefix.osy & ~p.oay);
            end
        end
    end

    assign Mode = dec.mode;
    assign RMW  = dec.rmw;
    assign phw  = dec.phw;

endmodule

//--- design/microProgramRom.sv
// Microprogram store as a case table, followed by the uPL pipeline register
// Routines: reset, fetch, interrupt entry, operand reads and PHW writes

`timescale 1ns/10ps

module microProgramRom
    import cpuFrontPkg::*;
#(
    parameter int uAddrWidth = 5
)(
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  Rdy,
    input  logic [uAddrWidth-1:0] MA,
    output microWordT             uPL
);

    microWordT uRom;                                // Word at MA

    always_comb
    begin
        uRom = uIdleWord;
        case (MA)
            // Reset: vector load, vector pull, then fall into fetch
            uAddrWidth'(entryReset):
                uRom.via = viaBrv2;
            uAddrWidth'(entryReset + 5'd1):
            begin
                uRom.isr = 1'b1;
                uRom.vp  = 1'b1;
            end
            uAddrWidth'(entryFetch):
            begin
                uRom.ioOp = ioFetch;
                uRom.via  = viaBrv3;
                uRom.isr  = 1'b1;                   // VP drops here
            end
            // Interrupt entry mirrors the reset routine
            uAddrWidth'(entryInt):
                uRom.via = viaBrv2;
            uAddrWidth'(entryInt + 5'd1):
            begin
                uRom.isr  = 1'b1;
                uRom.vp   = 1'b1;
                uRom.jump = 1'b1;
                uRom.ba   = entryFetch;
            end
            uAddrWidth'(entryOne):
            begin
                uRom.ioOp              = ioRead;
                uRom.ioSel.diSel.op1   = 1'b1;
                uRom.jump              = 1'b1;
                uRom.ba                = entryFetch;
            end
            uAddrWidth'(entryTwo), uAddrWidth'(entryPhw):
            begin
                uRom.ioOp              = ioRead;    // Low operand byte
                uRom.ioSel.diSel.op1   = 1'b1;
            end
            uAddrWidth'(entryTwo + 5'd1):
            begin
                uRom.ioOp              = ioRead;
                uRom.ioSel.diSel.op2   = 1'b1;
                uRom.jump              = 1'b1;
                uRom.ba                = entryFetch;
            end
            uAddrWidth'(entryPhw + 5'd1):
            begin
                uRom.ioOp              = ioRead;
                uRom.ioSel.diSel.op2   = 1'b1;
            end
            uAddrWidth'(entryPhw + 5'd2):
            begin
                uRom.ioOp              = ioWrite;   // High byte pushed first
                uRom.ioSel.doSel.hi    = 1'b1;
            end
            uAddrWidth'(entryPhw + 5'd3):
            begin
                uRom.ioOp              = ioWrite;
                uRom.ioSel.doSel.lo    = 1'b1;
                uRom.jump              = 1'b1;
                uRom.ba                = entryFetch;
            end
            default:
            begin
                uRom.jump = 1'b1;                   // Unused words recover at fetch
                uRom.ba   = entryFetch;
            end
        endcase
    end

    // Pipeline register, holds through a stall
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            uPL <= uIdleWord;
        end
        else if (Rdy)
        begin
            uPL <= uRom;
        end
    end

endmodule

//--- design/microSequencer.sv
// Microprogram address sequencer with the Via branch address multiplexer
// Produces MA from the current microword; the counter steps only with Rdy

`timescale 1ns/10ps

module microSequencer
    import cpuFrontPkg::*;
#(
    parameter int uAddrWidth = 5
)(
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  Rdy,
    input  microWordT             uPL,            // Current microword
    input  logic                  Int,            // Pending interrupt
    input  logic [uAddrWidth-1:0] dispatchAddr,   // Routine entry from decode
    output logic [uAddrWidth-1:0] MA
);

    ////////////////////////////////////////////////////////////////////////////
    // Local signals

    logic [uAddrWidth-1:0] uPC;                     // Address after current word
    logic                  dispatch;
    logic                  takeInt;

    // BRV1 and BRV3 both branch through the decoder
    assign dispatch = (uPL.via == viaBrv1) || (uPL.via == viaBrv3);

    // Int is only honoured on the fetch word
    assign takeInt = (uPL.via == viaBrv3) && Int;

    ////////////////////////////////////////////////////////////////////////////
    // Next address select

    always_comb
    begin
        if (uPL.jump)
        begin
            MA = uAddrWidth'(uPL.ba);               // Unconditional jump
        end
        else if (dispatch)
        begin
            MA = takeInt ? uAddrWidth'(entryInt) : dispatchAddr;
        end
        else
        begin
            MA = uPC;                               // Fall through
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Microprogram counter

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            uPC <= '0;                              // MA = reset routine
        end
        else if (Rdy)
        begin
            uPC <= MA + 1'b1;
        end
    end

endmodule

//--- design/operandPath.sv
// Operand registers OP1/OP2, vector pull flag and the data output mux
// Reads land at the end of the cycle; writes put OP2 or OP1 on DO

`timescale 1ns/10ps

module operandPath
    import cpuFrontPkg::*;
#(
    parameter logic [15:0] resetVector = 16'hFFFC
)(
    input  logic       Clk,
    input  logic       arstN,
    input  logic       Rdy,
    input  microWordT  uPL,
    input  logic       loadVector,          // BRV2 word
    input  logic       phw,                 // IR holds PHW
    input  logic [7:0] DI,
    input  logic [15:0] Vector,
    output logic [7:0] OP1,
    output logic [7:0] OP2,
    output logic [7:0] DO,
    output logic       VP
);

    logic rdCycle, wrCycle;
    logic ldOp1, ldOp2, ldVec;

    assign rdCycle = (uPL.ioOp == ioRead);
    assign wrCycle = (uPL.ioOp == ioWrite);
    assign ldVec   = loadVector & Rdy;
    assign ldOp1   = rdCycle & uPL.ioSel.diSel.op1 & Rdy;
    assign ldOp2   = rdCycle & uPL.ioSel.diSel.op2 & Rdy;

    ////////////////////////////////////////////////////////////////////////////
    // Operand registers and VP

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            OP1 <= resetVector[7:0];
            OP2 <= resetVector[15:8];
            VP  <= 1'b0;
        end
        else
        begin
            if (ldVec)
                OP1 <= Vector[7:0];         // Vector wins over a read
            else if (ldOp1)
                OP1 <= DI;
            if (ldVec)
                OP2 <= Vector[15:8];
            else if (ldOp2)
                OP2 <= DI;
            if (Rdy && uPL.isr)
                VP <= uPL.vp;               // Set on entry, cleared at fetch
        end
    end

    // Write data, only PHW has a source here
    always_comb
    begin
        DO = '0;
        if (wrCycle && phw)
        begin
            if (uPL.ioSel.doSel.hi)
                DO = OP2;
            else if (uPL.ioSel.doSel.lo)
                DO = OP1;
        end
    end

endmodule

//--- project.f
design/cpuFrontPkg.sv
design/microSequencer.sv
design/microProgramRom.sv
design/instructionUnit.sv
design/operandPath.sv
design/cpuFront.sv
test/cpuFront_assert.sv
test/cpuFrontTb.sv

//--- test/cpuFrontTb.sv
// Testbench for the instruction front end with random opcodes, stalls and interrupts
// A port-level model predicts IR, decode, prefixes, operands, VP and the bus cycle sequence

`timescale 1ns/10ps

module cpuFrontTb
    import cpuFrontPkg::*;
();

    localparam logic [15:0] resetVec     = 16'hFFFC;
    localparam int          numInstr     = 600;     // Fetches to run
    localparam int          fetchTimeout = 64;      // Cycles allowed per instruction

    // Expected bus cycles queued behind a fetch
    typedef enum logic [2:0] {
        stFetch, stBoot, stVec, stIsr, stRd1, stRd2, stWrHi, stWrLo
    } stepT;

    logic        Clk, arstN, Int, Wait;
    logic [15:0] Vector;
    logic [7:0]  DI;
    logic        Done, SC, Rdy, LE_Int, VP, RMW;
    ioOpT        IO_Op;
    logic [7:0]  DO, IR, OP1, OP2;
    modeT        Mode;
    prefixT      prefix;

    // Model state as the ports should show it this cycle
    logic [7:0]  mIR, mOP1, mOP2;
    modeT        mMode;
    logic        mRMW, mVP;
    prefixT      mPfx;
    stepT        busQ[$];

    // Previous cycle values for the stall hold check
    logic        prevStall;
    ioOpT        prevIO;
    logic [7:0]  prevDO, prevIR, prevOP1, prevOP2;
    prefixT      prevPfx;

    int errCnt, checkCnt, fetchCnt, intCnt, phwCnt, pfxCnt, waitCnt;
    bit timedOut;

    cpuFront #(.uAddrWidth(5), .resetVector(resetVec)) UUT (
        .Clk(Clk), .arstN(arstN), .Int(Int), .Wait(Wait),
        .Vector(Vector), .DI(DI),
        .Done(Done), .SC(SC), .Rdy(Rdy), .LE_Int(LE_Int), .VP(VP),
        .IO_Op(IO_Op), .DO(DO), .IR(IR), .OP1(OP1), .OP2(OP2),
        .Mode(Mode), .RMW(RMW), .prefix(prefix)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;                     // 100 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules

    // Opcode class, operand count and RMW straight from the decode rules
    function automatic decodeT refDecode(input logic [7:0] b);
        decodeT d;
        d = '0;
        if (b == opPfxOsy || b == opPfxInd || b == opPfxSiz || b == opPfxIsz
            || b == opPfxOax || b == opPfxOay)
        begin
            d.mode       = modePrefix;
            d.prefix.ind = (b == opPfxInd) || (b == opPfxIsz);
            d.prefix.siz = (b == opPfxSiz) || (b == opPfxIsz);
            d.prefix.oax = (b == opPfxOax);
            d.prefix.oay = (b == opPfxOay);
            d.prefix.osy = (b == opPfxOsy);
        end
        else if (b == opPhw)
        begin
            d.mode = modeSpecial;
            d.phw  = 1'b1;
        end
        else if (b == opBrk)
            d.mode = modeBrk;
        else if (b == opCop)
            d.mode = modeCop;
        else if (b[3:0] == 4'hB)
            d.mode = modeInvalid;                   // Unlisted xB codes
        else
            d.mode = modeValid;
        if (b[3:2] == 2'b11 || b == opPhw)
            d.opCnt = 2'd2;
        else if (b[0] || b[3:2] == 2'b01)
            d.opCnt = 2'd1;
        else
            d.opCnt = 2'd0;
        d.rmw = (b[2:1] == 2'b11) && !b[0];
        return d;
    endfunction

    // Prefix flags after an opcode is taken into IR
    function automatic prefixT nextPrefix(input prefixT cur, input decodeT d);
        prefixT n;
        n = '0;                                     // Real opcode clears the chain
        if (d.mode == modePrefix)
        begin
            n.ind = cur.ind | d.prefix.ind;
            n.siz = cur.siz | d.prefix.siz;
            n.oax = d.prefix.oax ? 1'b1 : (d.prefix.oay ? 1'b0 : cur.oax);
            n.oay = d.prefix.oay ? 1'b1 : ((d.prefix.osy | d.prefix.oax) ? 1'b0 : cur.oay);
            n.osy = d.prefix.osy ? 1'b1 : (d.prefix.oay ? 1'b0 : cur.osy);
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // DI leans toward prefixes and PHW so chains and pushes show up often
    function automatic logic [7:0] pickOpcode();
        int pick;
        int k;
        logic [7:0] b;
        pick = $urandom % 20;
        k    = $urandom % 6;
        b    = 8'($urandom);
        if (pick < 7)
        begin
            case (k)
                0:       b = opPfxOsy;
                1:       b = opPfxInd;
                2:       b = opPfxSiz;
                3:       b = opPfxIsz;
                4:       b = opPfxOax;
                default: b = opPfxOay;
            endcase
        end
        else if (pick < 9)
            b = opPhw;
        else if (pick == 9)
            b = (k < 3) ? opBrk : opCop;
        return b;
    endfunction

    task automatic driveInputs();
        DI     = pickOpcode();
        Wait   = ($urandom % 5) == 0;               // About 1 in 5 cycles stalled
        Int    = ($urandom % 10) == 0;              // Single cycle pulse
        Vector = 16'($urandom);
    endtask

    task automatic reportMismatch(input string what, input logic [15:0] got,
                                  input logic [15:0] exp);
        errCnt++;
        $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle check and model update at the falling edge

    task automatic checkCycle(output bit fetched);
        stepT       st;
        decodeT     d;
        ioOpT       expIO;
        logic [7:0] expDO;
        logic       expDone, expSC, expLE;
        fetched = 1'b0;
        st      = (busQ.size() == 0) ? stFetch : busQ[0];
        expIO   = ioIdle;
        expDO   = 8'h00;
        expDone = 1'b0;
        expSC   = 1'b0;
        expLE   = 1'b0;
        case (st)
            stFetch:
            begin
                expIO   = ioFetch;
                expDone = 1'b1;
                expSC   = 1'b1;
            end
            stVec:
            begin
                expDone = 1'b1;                     // BRV2 ends the instruction
                expLE   = 1'b1;
            end
            stRd1, stRd2: expIO = ioRead;
            stWrHi:
            begin
                expIO = ioWrite;
                expDO = mOP2;                       // High byte first
            end
            stWrLo:
            begin
                expIO = ioWrite;
                expDO = mOP1;
            end
            default: expIO = ioIdle;
        endcase

        checkCnt++;
        if (IO_Op !== expIO)     reportMismatch("IO_Op", 16'(IO_Op), 16'(expIO));
        if (Done !== expDone)    reportMismatch("Done", 16'(Done), 16'(expDone));
        if (SC !== expSC)        reportMismatch("SC", 16'(SC), 16'(expSC));
        if (LE_Int !== expLE)    reportMismatch("LE_Int", 16'(LE_Int), 16'(expLE));
        if (DO !== expDO)        reportMismatch("DO", 16'(DO), 16'(expDO));
        if (Rdy !== !Wait)       reportMismatch("Rdy", 16'(Rdy), 16'(!Wait));
        if (IR !== mIR)          reportMismatch("IR", 16'(IR), 16'(mIR));
        if (Mode !== mMode)      reportMismatch("Mode", 16'(Mode), 16'(mMode));
        if (RMW !== mRMW)        reportMismatch("RMW", 16'(RMW), 16'(mRMW));
        if (prefix !== mPfx)     reportMismatch("prefix", 16'(prefix), 16'(mPfx));
        if (OP1 !== mOP1)        reportMismatch("OP1", 16'(OP1), 16'(mOP1));
        if (OP2 !== mOP2)        reportMismatch("OP2", 16'(OP2), 16'(mOP2));
        if (VP !== mVP)          reportMismatch("VP", 16'(VP), 16'(mVP));

        // A stalled cycle must repeat the one before it
        if (prevStall)
        begin
            if (IO_Op !== prevIO)
                reportMismatch("held IO_Op", 16'(IO_Op), 16'(prevIO));
            if (DO !== prevDO)
                reportMismatch("held DO", 16'(DO), 16'(prevDO));
            if (IR !== prevIR)
                reportMismatch("held IR", 16'(IR), 16'(prevIR));
            if (OP1 !== prevOP1)
                reportMismatch("held OP1", 16'(OP1), 16'(prevOP1));
            if (OP2 !== prevOP2)
                reportMismatch("held OP2", 16'(OP2), 16'(prevOP2));
            if (prefix !== prevPfx)
                reportMismatch("held prefix", 16'(prefix), 16'(prevPfx));
        end

        prevStall = !Rdy;
        prevIO    = IO_Op;
        prevDO    = DO;
        prevIR    = IR;
        prevOP1   = OP1;
        prevOP2   = OP2;
        prevPfx   = prefix;
        if (!Rdy)
            waitCnt++;

        if (Rdy)
        begin
            case (st)
                stFetch:
                begin
                    fetched = 1'b1;
                    fetchCnt++;
                    mVP = 1'b0;                     // Fetch word clears VP
                    if (Int)
                    begin
                        intCnt++;                   // IR untouched while the handler runs
                        busQ.push_back(stVec);
                        busQ.push_back(stIsr);
                    end
                    else
                    begin
                        d     = refDecode(DI);
                        mIR   = DI;
                        mMode = d.mode;
                        mRMW  = d.rmw;
                        mPfx  = nextPrefix(mPfx, d);
                        if (d.mode == modePrefix)
                            pfxCnt++;
                        if (d.opCnt != 2'd0)
                            busQ.push_back(stRd1);
                        if (d.opCnt == 2'd2)
                            busQ.push_back(stRd2);
                        if (d.phw)
                        begin
                            phwCnt++;
                            busQ.push_back(stWrHi);
                            busQ.push_back(stWrLo);
                        end
                    end
                end
                stVec:
                begin
                    mOP1 = Vector[7:0];
                    mOP2 = Vector[15:8];
                end
                stIsr:   mVP  = 1'b1;
                stRd1:   mOP1 = DI;
                stRd2:   mOP2 = DI;
                default: ;                          // Boot and writes change no state
            endcase
            if (st != stFetch)
                void'(busQ.pop_front());
        end
    endtask

    task automatic runCycle(output bit fetched);
        @(negedge Clk);
        checkCycle(fetched);
        @(posedge Clk);
        #10;
        driveInputs();
    endtask

    // Runs cycles until a fetch is accepted
    task automatic waitFetch();
        int  cycles;
        bit  fetched;
        cycles  = 0;
        fetched = 1'b0;
        while (!fetched && cycles < fetchTimeout)
        begin
            runCycle(fetched);
            cycles++;
        end
        if (!fetched)
        begin
            timedOut = 1'b1;
            $display("timeout: no fetch accepted within %0d cycles at %0t",
                     fetchTimeout, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        void'($urandom(32'haf96_3d04));
        arstN    = 1'b0;
        Int      = 1'b0;
        Wait     = 1'b0;
        DI       = opNop;
        Vector   = 16'h0000;
        errCnt   = 0;
        checkCnt = 0;
        fetchCnt = 0;
        intCnt   = 0;
        phwCnt   = 0;
        pfxCnt   = 0;
        waitCnt  = 0;
        timedOut = 1'b0;
        // Reset state, then the boot words idle, vector load and vector pull
        mIR       = opNop;
        mMode     = modeValid;
        mRMW      = 1'b0;
        mPfx      = '0;
        mOP1      = resetVec[7:0];
        mOP2      = resetVec[15:8];
        mVP       = 1'b0;
        prevStall = 1'b0;
        busQ.push_back(stBoot);
        busQ.push_back(stVec);
        busQ.push_back(stIsr);

        repeat (2) @(posedge Clk);
        #10;
        arstN = 1'b1;
        driveInputs();

        for (int n = 0; n < numInstr && !timedOut; n++)
            waitFetch();

        // Each behavior must have come up at least once
        if (intCnt == 0 || phwCnt == 0 || pfxCnt == 0 || waitCnt == 0)
        begin
            errCnt++;
            $display("stimulus never reached an interrupt, PHW, prefix or stall");
        end

        $display("cycles %0d fetches %0d ints %0d PHW %0d prefixes %0d stalls %0d errors %0d",
                 checkCnt, fetchCnt, intCnt, phwCnt, pfxCnt, waitCnt, errCnt);
        if (timedOut || errCnt != 0)
        begin
            $display("test failed");
        end
        else
        begin
            $display("test passed");
        end
        $finish;
    end

endmodule

//--- test/cpuFront_assert.sv
// Concurrent checks on the front end strobes and the stall behavior
// Attached to every cpuFront instance by the bind at the bottom

`timescale 1ns/10ps

module cpuFrontAssert
    import cpuFrontPkg::*;
(
    input logic       Clk,
    input logic       arstN,
    input logic       Done,
    input logic       SC,
    input logic       LE_Int,
    input logic       Rdy,
    input ioOpT       IO_Op,
    input logic [7:0] IR
);

    // Only the fetch word carries BRV3, so SC marks a fetch that ends an instruction
    scDone: assert property (@(posedge Clk) disable iff (!arstN)
        SC |-> (Done && IO_Op == ioFetch))
        else $error("SC high without Done or outside a fetch cycle");

    // Vector load and fetch are separate words
    leNoFetch: assert property (@(posedge Clk) disable iff (!arstN)
        !(LE_Int && IO_Op == ioFetch))
        else $error("LE_Int during a fetch cycle");

    // Nothing moves across an edge with Rdy low
    stallHold: assert property (@(posedge Clk) disable iff (!arstN)
        !Rdy |=> ($stable(IR) && $stable(IO_Op)))
        else $error("IR or IO_Op changed during a stall");

endmodule

bind cpuFront cpuFrontAssert uChk (
    .Clk(Clk), .arstN(arstN), .Done(Done), .SC(SC),
    .LE_Int(LE_Int), .Rdy(Rdy), .IO_Op(IO_Op), .IR(IR)
);
